//--- verilog/gb_timer_pkg.sv
package gb_timer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // CPU bus address and register byte
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // Free running divider, DIV is its upper byte
    typedef logic [15:0] div_t;

    // One bit per source: vblank, lcd, timer, serial, joypad
    typedef logic [4:0]  irq_bits_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    localparam addr_t ADDR_DIV  = 16'hFF04;
    localparam addr_t ADDR_TIMA = 16'hFF05;
    localparam addr_t ADDR_TMA  = 16'hFF06;
    localparam addr_t ADDR_TAC  = 16'hFF07;
    localparam addr_t ADDR_IF   = 16'hFF0F;
    localparam addr_t ADDR_IE   = 16'hFFFF;

    // Bit positions
    localparam int IRQ_TIMER      = 2;
    localparam int TAC_ENABLE_BIT = 2;

    // TIMA sequencing, reload happens one cycle after the wrap
    typedef enum logic {
        TIMA_RUN,
        TIMA_OVERFLOW
    } tima_state_t;

endpackage

//--- verilog/io_bus.sv
module io_bus (
    input  gb_timer_pkg::addr_t addr,
    input  logic                rd,
    input  gb_timer_pkg::data_t timer_rdata,
    input  gb_timer_pkg::data_t intc_rdata,
    output logic                timer_sel,
    output logic                intc_sel,
    output gb_timer_pkg::data_t rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    // Timer owns FF04 to FF07
    assign timer_sel = (addr >= gb_timer_pkg::ADDR_DIV)
                    && (addr <= gb_timer_pkg::ADDR_TAC);

    // IF and IE are not contiguous
    assign intc_sel = (addr == gb_timer_pkg::ADDR_IF)
                   || (addr == gb_timer_pkg::ADDR_IE);

    ////////////////////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////////////////////

    // Idle bus and unmapped space float high
    always_comb begin
        if (!rd) begin
            rdata = 8'hFF;
        end else if (timer_sel) begin
            rdata = timer_rdata;
        end else if (intc_sel) begin
            rdata = intc_rdata;
        end else begin
            rdata = 8'hFF;
        end
    end

endmodule

//--- verilog/timer.sv
module timer (
    input  logic                clk_1m,
    input  logic                rst,
    input  gb_timer_pkg::addr_t addr,
    input  gb_timer_pkg::data_t wdata,
    input  logic                wr,
    input  logic                sel,
    input  logic                int_tim_ack,
    output gb_timer_pkg::data_t rdata,
    output logic                int_tim_req
);

    // Divider and the three timer registers
    gb_timer_pkg::div_t        div_cnt;
    gb_timer_pkg::data_t       tima;
    gb_timer_pkg::data_t       tma;
    gb_timer_pkg::data_t       tac;
    gb_timer_pkg::tima_state_t state;

    // Tap edge detection
    logic tap;
    logic tap_prev;
    logic tick;

    // Write and reload qualifiers
    logic       bus_wr;
    logic       reload;
    logic [8:0] tima_inc;

    assign bus_wr = wr && sel;

    // A pending reload waits while the bus writes any timer register
    assign reload = (state == gb_timer_pkg::TIMA_OVERFLOW) && !bus_wr;

    // Ninth bit is the carry out of FF
    assign tima_inc = {1'b0, tima} + 9'd1;

    ////////////////////////////////////////////////////////////////////////////
    // Divider and tap selection
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_1m) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (bus_wr && (addr == gb_timer_pkg::ADDR_DIV)) begin
            // Any write to DIV clears the whole divider
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // TAC bits 1:0 pick the divider bit, bit 2 gates it
    always_comb begin
        case (tac[1:0])
            2'b00:   tap = div_cnt[9];
            2'b01:   tap = div_cnt[3];
            2'b10:   tap = div_cnt[5];
            default: tap = div_cnt[7];
        endcase
        tap = tap && tac[gb_timer_pkg::TAC_ENABLE_BIT];
    end

    always_ff @(posedge clk_1m) begin
        if (rst) begin
            tap_prev <= 1'b0;
        end else begin
            tap_prev <= tap;
        end
    end

    // Rising edge of the selected tap
    assign tick = tap && !tap_prev;

    ////////////////////////////////////////////////////////////////////////////
    // TIMA, TMA, TAC
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_1m) begin
        if (rst) begin
            tima  <= '0;
            tma   <= '0;
            tac   <= '0;
            state <= gb_timer_pkg::TIMA_RUN;
        end else if (bus_wr) begin
            // Bus write beats increment and reload
            case (addr)
                gb_timer_pkg::ADDR_TIMA: tima <= wdata;
                gb_timer_pkg::ADDR_TMA:  tma  <= wdata;
                gb_timer_pkg::ADDR_TAC:  tac  <= wdata;
                default: ;
            endcase
        end else if (reload) begin
            tima  <= tma;
            state <= gb_timer_pkg::TIMA_RUN;
        end else if (tick) begin
            tima <= tima_inc[7:0];
            if (tima_inc[8]) begin
                state <= gb_timer_pkg::TIMA_OVERFLOW;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt request
    ////////////////////////////////////////////////////////////////////////////

    // Raised with the reload, held until the controller acknowledges it.
    // A new reload while still high just merges.
    always_ff @(posedge clk_1m) begin
        if (rst) begin
            int_tim_req <= 1'b0;
        end else if (reload) begin
            int_tim_req <= 1'b1;
        end else if (int_tim_req && int_tim_ack) begin
            int_tim_req <= 1'b0;
        end
    end

    // Register read
    always_comb begin
        case (addr)
            gb_timer_pkg::ADDR_DIV:  rdata = div_cnt[15:8];
            gb_timer_pkg::ADDR_TIMA: rdata = tima;
            gb_timer_pkg::ADDR_TMA:  rdata = tma;
            gb_timer_pkg::ADDR_TAC:  rdata = tac;
            default:                 rdata = 8'hFF;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Request only drops after the controller has seen it
    req_held_until_ack: assert property (
        @(posedge clk_1m) disable iff (rst)
        ($fell(int_tim_req) && !$past(rst)) |-> $past(int_tim_ack)
    );

    // Overflow lasting two cycles means a write held the reload off
    overflow_one_cycle: assert property (
        @(posedge clk_1m) disable iff (rst)
        ((state == gb_timer_pkg::TIMA_OVERFLOW)
            && $past(state == gb_timer_pkg::TIMA_OVERFLOW)) |-> $past(bus_wr)
    );

endmodule

//--- verilog/interrupt_ctrl.sv
module interrupt_ctrl #(
    parameter gb_timer_pkg::addr_t VECTOR_BASE   = 16'h0040,
    parameter integer              VECTOR_STRIDE = 8
) (
    input  logic                clk_1m,
    input  logic                rst,
    input  gb_timer_pkg::addr_t addr,
    input  gb_timer_pkg::data_t wdata,
    input  logic                wr,
    input  logic                sel,
    input  logic                int_tim_req,
    input  logic [3:0]          irq_ext,
    input  logic                irq_taken,
    output gb_timer_pkg::data_t rdata,
    output logic                int_tim_ack,
    output logic                irq,
    output gb_timer_pkg::addr_t vector
);

    gb_timer_pkg::irq_bits_t if_q;
    gb_timer_pkg::data_t     ie_q;

    gb_timer_pkg::irq_bits_t pending;
    gb_timer_pkg::irq_bits_t set_bits;
    gb_timer_pkg::irq_bits_t clear_bits;
    gb_timer_pkg::irq_bits_t if_next;
    logic [2:0]              pend_idx;
    logic                    tim_capture;
    logic                    if_wr;
    logic                    ie_wr;

    assign if_wr = wr && sel && (addr == gb_timer_pkg::ADDR_IF);
    assign ie_wr = wr && sel && (addr == gb_timer_pkg::ADDR_IE);

    ////////////////////////////////////////////////////////////////////////////
    // Request capture
    ////////////////////////////////////////////////////////////////////////////

    // New timer request seen, ack goes out on this same edge
    assign tim_capture = int_tim_req && !int_tim_ack;

    always_ff @(posedge clk_1m) begin
        if (rst) begin
            int_tim_ack <= 1'b0;
        end else begin
            int_tim_ack <= tim_capture;
        end
    end

    // External pulses are vblank, lcd, serial, joypad
    always_comb begin
        set_bits                          = {irq_ext[3:2], 1'b0, irq_ext[1:0]};
        set_bits[gb_timer_pkg::IRQ_TIMER] = tim_capture;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Priority and vector
    ////////////////////////////////////////////////////////////////////////////

    assign pending = if_q & ie_q[4:0];
    assign irq     = |pending;

    // Lowest index wins, so scan downwards
    always_comb begin
        pend_idx = '0;
        for (int i = 4; i >= 0; i--) begin
            if (pending[i]) begin
                pend_idx = 3'(i);
            end
        end
    end

    assign vector = VECTOR_BASE
                  + gb_timer_pkg::addr_t'(VECTOR_STRIDE) * gb_timer_pkg::addr_t'(pend_idx);

    // Taken clears the source the vector pointed at
    assign clear_bits = (irq_taken && irq) ? (5'b00001 << pend_idx) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // IF and IE
    ////////////////////////////////////////////////////////////////////////////

    // Ordering: set requests, then bus write, then taken
    always_comb begin
        if_next = if_q & ~clear_bits;
        if (if_wr) begin
            if_next = wdata[4:0];
        end
        if_next = if_next | set_bits;
    end

    always_ff @(posedge clk_1m) begin
        if (rst) begin
            if_q <= '0;
            ie_q <= '0;
        end else begin
            if_q <= if_next;
            if (ie_wr) begin
                ie_q <= wdata;
            end
        end
    end

    // Unused IF bits read back as ones
    always_comb begin
        case (addr)
            gb_timer_pkg::ADDR_IF: rdata = {3'b111, if_q};
            gb_timer_pkg::ADDR_IE: rdata = ie_q;
            default:               rdata = 8'hFF;
        endcase
    end

    // CPU only takes an interrupt that is actually raised
    taken_while_irq: assert property (
        @(posedge clk_1m) disable iff (rst)
        irq_taken |-> irq
    );

endmodule

//--- verilog/timer_subsystem.sv
module timer_subsystem #(
    parameter gb_timer_pkg::addr_t VECTOR_BASE   = 16'h0040,
    parameter integer              VECTOR_STRIDE = 8
) (
    input  logic                clk_1m,
    input  logic                rst,
    input  gb_timer_pkg::addr_t addr,
    input  gb_timer_pkg::data_t wdata,
    input  logic                wr,
    input  logic                rd,
    input  logic [3:0]          irq_ext,
    input  logic                irq_taken,
    output gb_timer_pkg::data_t rdata,
    output logic                irq,
    output gb_timer_pkg::addr_t vector
);

    // Block selects and read data
    logic                timer_sel;
    logic                intc_sel;
    gb_timer_pkg::data_t timer_rdata;
    gb_timer_pkg::data_t intc_rdata;

    // Timer interrupt handshake
    logic int_tim_req;
    logic int_tim_ack;

    io_bus u_io_bus (
        .addr        (addr),
        .rd          (rd),
        .timer_rdata (timer_rdata),
        .intc_rdata  (intc_rdata),
        .timer_sel   (timer_sel),
        .intc_sel    (intc_sel),
        .rdata       (rdata)
    );

    timer u_timer (
        .clk_1m      (clk_1m),
        .rst         (rst),
        .addr        (addr),
        .wdata       (wdata),
        .wr          (wr),
        .sel         (timer_sel),
        .int_tim_ack (int_tim_ack),
        .rdata       (timer_rdata),
        .int_tim_req (int_tim_req)
    );

    interrupt_ctrl #(
        .VECTOR_BASE   (VECTOR_BASE),
        .VECTOR_STRIDE (VECTOR_STRIDE)
    ) u_interrupt_ctrl (
        .clk_1m      (clk_1m),
        .rst         (rst),
        .addr        (addr),
        .wdata       (wdata),
        .wr          (wr),
        .sel         (intc_sel),
        .int_tim_req (int_tim_req),
        .irq_ext     (irq_ext),
        .irq_taken   (irq_taken),
        .rdata       (intc_rdata),
        .int_tim_ack (int_tim_ack),
        .irq         (irq),
        .vector      (vector)
    );

endmodule

//--- tb/tb_timer_subsystem.sv
module tb_timer_subsystem;

    localparam int                  CLK_PERIOD    = 20;
    localparam gb_timer_pkg::addr_t VECTOR_BASE   = 16'h0040;
    localparam int                  VECTOR_STRIDE = 8;

    // Four TIMA sweeps of about four periods each dominate the run
    localparam int TEST_CYCLES   = 4 * (1024 + 16 + 64 + 256) + 1000;
    localparam int MARGIN_CYCLES = 13000;

    localparam gb_timer_pkg::addr_t UNMAPPED [0:5] = '{
        16'h0000, 16'hFF00, 16'hFF03, 16'hFF08, 16'hFF0E, 16'hFFFE
    };

    logic                clk_1m;
    logic                rst;
    gb_timer_pkg::addr_t addr;
    gb_timer_pkg::data_t wdata;
    logic                wr;
    logic                rd;
    logic [3:0]          irq_ext;
    logic                irq_taken;
    gb_timer_pkg::data_t rdata;
    logic                irq;
    gb_timer_pkg::addr_t vector;

    // Reference model state
    gb_timer_pkg::div_t      m_div;
    gb_timer_pkg::data_t     m_tima;
    gb_timer_pkg::data_t     m_tma;
    gb_timer_pkg::data_t     m_tac;
    gb_timer_pkg::data_t     m_ie;
    gb_timer_pkg::irq_bits_t m_if;
    logic                    m_ovf;
    logic                    m_tap_prev;
    logic                    m_tim_new;

    gb_timer_pkg::irq_bits_t exp_pend;
    logic                    exp_irq;
    gb_timer_pkg::addr_t     exp_vector;

    timer_subsystem #(
        .VECTOR_BASE   (VECTOR_BASE),
        .VECTOR_STRIDE (VECTOR_STRIDE)
    ) uut (
        .clk_1m    (clk_1m),
        .rst       (rst),
        .addr      (addr),
        .wdata     (wdata),
        .wr        (wr),
        .rd        (rd),
        .irq_ext   (irq_ext),
        .irq_taken (irq_taken),
        .rdata     (rdata),
        .irq       (irq),
        .vector    (vector)
    );

    initial begin
        clk_1m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_1m = ~clk_1m;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        stop_on_error("Watchdog expired before all tests had finished");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Divider bit per TAC select, from the timer table
    function automatic logic tap_of(input gb_timer_pkg::div_t d, input gb_timer_pkg::data_t tac);
        int b;
        case (tac[1:0])
            2'b00:   b = 9;
            2'b01:   b = 3;
            2'b10:   b = 5;
            default: b = 7;
        endcase
        return d[b] & tac[gb_timer_pkg::TAC_ENABLE_BIT];
    endfunction

    function automatic int period_of(input logic [1:0] sel);
        case (sel)
            2'b00:   return 1024;
            2'b01:   return 16;
            2'b10:   return 64;
            default: return 256;
        endcase
    endfunction

    function automatic logic [2:0] lowest_index(input gb_timer_pkg::irq_bits_t bits);
        logic [2:0] idx;
        logic       found;
        idx   = '0;
        found = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (bits[i] && !found) begin
                idx   = 3'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    function automatic gb_timer_pkg::data_t expected_read(input gb_timer_pkg::addr_t a,
                                                          input logic r);
        if (!r) begin
            return 8'hFF;
        end
        case (a)
            gb_timer_pkg::ADDR_DIV:  return m_div[15:8];
            gb_timer_pkg::ADDR_TIMA: return m_tima;
            gb_timer_pkg::ADDR_TMA:  return m_tma;
            gb_timer_pkg::ADDR_TAC:  return m_tac;
            gb_timer_pkg::ADDR_IF:   return {3'b111, m_if};
            gb_timer_pkg::ADDR_IE:   return m_ie;
            default:                 return 8'hFF;
        endcase
    endfunction

    always @(posedge clk_1m) begin : ref_model
        logic                    timer_wr;
        logic                    tick;
        gb_timer_pkg::irq_bits_t pend;
        gb_timer_pkg::irq_bits_t nxt;
        timer_wr = wr && (addr >= gb_timer_pkg::ADDR_DIV) && (addr <= gb_timer_pkg::ADDR_TAC);
        tick     = tap_of(m_div, m_tac) && !m_tap_prev;
        pend     = m_if & m_ie[4:0];
        if (rst) begin
            m_div      <= '0;
            m_tima     <= '0;
            m_tma      <= '0;
            m_tac      <= '0;
            m_ie       <= '0;
            m_if       <= '0;
            m_ovf      <= 1'b0;
            m_tap_prev <= 1'b0;
            m_tim_new  <= 1'b0;
        end else begin
            m_div      <= (wr && addr == gb_timer_pkg::ADDR_DIV) ? '0 : m_div + 16'd1;
            m_tap_prev <= tap_of(m_div, m_tac);
            m_tim_new  <= 1'b0;
            // Bus write first, then the pending reload, then the tick
            if (timer_wr) begin
                if (addr == gb_timer_pkg::ADDR_TIMA) m_tima <= wdata;
                if (addr == gb_timer_pkg::ADDR_TMA)  m_tma  <= wdata;
                if (addr == gb_timer_pkg::ADDR_TAC)  m_tac  <= wdata;
            end else if (m_ovf) begin
                m_tima    <= m_tma;
                m_ovf     <= 1'b0;
                m_tim_new <= 1'b1;
            end else if (tick) begin
                m_tima <= m_tima + 8'd1;
                m_ovf  <= (m_tima == 8'hFF);
            end
            // IF sees the timer request one edge after the reload
            nxt = m_if;
            if (irq_taken && (pend != '0)) begin
                nxt[lowest_index(pend)] = 1'b0;
            end
            if (wr && addr == gb_timer_pkg::ADDR_IF) begin
                nxt = wdata[4:0];
            end
            m_if <= nxt | {irq_ext[3:2], m_tim_new, irq_ext[1:0]};
            if (wr && addr == gb_timer_pkg::ADDR_IE) begin
                m_ie <= wdata;
            end
        end
    end

    assign exp_pend   = m_if & m_ie[4:0];
    assign exp_irq    = |exp_pend;
    assign exp_vector = VECTOR_BASE + 16'(VECTOR_STRIDE * int'(lowest_index(exp_pend)));

    irq_matches_model: assert property (
        @(posedge clk_1m) disable iff (rst)
        irq == exp_irq
    ) else stop_on_error($sformatf("** Error: irq = %h, expected %h",
                                   $sampled(irq), $sampled(exp_irq)));

    vector_matches_model: assert property (
        @(posedge clk_1m) disable iff (rst)
        irq |-> (vector == exp_vector)
    ) else stop_on_error($sformatf("** Error: vector = %h, expected %h",
                                   $sampled(vector), $sampled(exp_vector)));

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected)
            else stop_on_error($sformatf("** Error: %s = %h, expected %h", name, got, expected));
    endtask

    // Outputs have settled half a cycle after the edge
    task automatic next_cycle();
        @(negedge clk_1m);
        if (!rst) begin
            check_value($sformatf("rdata at %h", addr), 16'(rdata), 16'(expected_read(addr, rd)));
        end
    endtask

    task automatic bus_write(input gb_timer_pkg::addr_t a, input gb_timer_pkg::data_t d);
        next_cycle();
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        rd    = 1'b0;
        next_cycle();
        wr = 1'b0;
        rd = 1'b1;
    endtask

    task automatic bus_read(input gb_timer_pkg::addr_t a, output gb_timer_pkg::data_t d);
        next_cycle();
        addr = a;
        wr   = 1'b0;
        rd   = 1'b1;
        next_cycle();
        d = rdata;
    endtask

    task automatic pulse_ext(input logic [3:0] bits);
        next_cycle();
        irq_ext = bits;
        next_cycle();
        irq_ext = 4'h0;
    endtask

    task automatic take_interrupt();
        next_cycle();
        irq_taken = 1'b1;
        next_cycle();
        irq_taken = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_div();
        gb_timer_pkg::data_t d;
        bus_write(gb_timer_pkg::ADDR_DIV, 8'($urandom));
        // Divider cleared at the write edge, reads keep it running
        for (int i = 0; i < 599; i++) begin
            next_cycle();
            rd = 1'($urandom);
        end
        rd = 1'b1;
        next_cycle();
        check_value("DIV after 600 cycles", 16'(rdata), 16'(600 >> 8));
        bus_write(gb_timer_pkg::ADDR_DIV, 8'h00);
        bus_read(gb_timer_pkg::ADDR_DIV, d);
        check_value("DIV after clear", 16'(d), 16'h0000);
    endtask

    task automatic test_tima(input logic [1:0] sel);
        int period;
        period = period_of(sel);
        bus_write(gb_timer_pkg::ADDR_TAC, {6'b0, sel});
        bus_write(gb_timer_pkg::ADDR_DIV, 8'h00);
        bus_write(gb_timer_pkg::ADDR_TIMA, 8'h00);
        bus_write(gb_timer_pkg::ADDR_TAC, {5'b0, 1'b1, sel});
        // Four cycles have passed since the divider clear
        addr = gb_timer_pkg::ADDR_TIMA;
        repeat (3 * period - 4) next_cycle();
        check_value("TIMA after three periods", 16'(rdata), 16'd3);
        bus_write(gb_timer_pkg::ADDR_TAC, {6'b0, sel});
        addr = gb_timer_pkg::ADDR_TIMA;
        repeat (period + 4) next_cycle();
        check_value("TIMA while disabled", 16'(rdata), 16'd3);
    endtask

    task automatic test_overflow();
        gb_timer_pkg::data_t tma_val;
        gb_timer_pkg::data_t d;
        int                  edges;
        tma_val = 8'($urandom_range(255, 1));
        bus_write(gb_timer_pkg::ADDR_TAC, 8'h01);
        bus_write(gb_timer_pkg::ADDR_IF, 8'h00);
        bus_write(gb_timer_pkg::ADDR_IE, 8'h04);
        bus_write(gb_timer_pkg::ADDR_TMA, tma_val);
        bus_write(gb_timer_pkg::ADDR_TIMA, 8'hFF);
        bus_write(gb_timer_pkg::ADDR_TAC, 8'h05);
        addr  = gb_timer_pkg::ADDR_TIMA;
        edges = 0;
        // Wait for the wrap to 00
        while (edges == 0 || rdata !== 8'h00) begin
            next_cycle();
            edges++;
            if (edges > 64) begin
                stop_on_error("TIMA did not overflow within 64 cycles");
            end
        end
        check_value("irq at overflow", 16'(irq), 16'h0000);
        next_cycle();
        check_value("TIMA after reload", 16'(rdata), 16'(tma_val));
        edges = 2;
        while (!irq) begin
            next_cycle();
            edges++;
            if (edges > 8) begin
                stop_on_error("irq did not rise after the TIMA overflow");
            end
        end
        check_value("edges from overflow to irq", 16'(edges), 16'd3);
        bus_write(gb_timer_pkg::ADDR_TAC, 8'h00);
        bus_read(gb_timer_pkg::ADDR_IF, d);
        check_value("IF after overflow", 16'(d), 16'h00E4);
    endtask

    task automatic test_priority();
        gb_timer_pkg::data_t d;
        // Timer bit is still pending from the overflow
        bus_write(gb_timer_pkg::ADDR_IE, 8'h1F);
        pulse_ext(4'hF);
        for (int i = 0; i < 5; i++) begin
            check_value("irq", 16'(irq), 16'h0001);
            check_value("vector", vector, VECTOR_BASE + 16'(VECTOR_STRIDE * i));
            take_interrupt();
        end
        check_value("irq with nothing left", 16'(irq), 16'h0000);
        // Masked sources stay in IF but raise nothing
        pulse_ext(4'hF);
        bus_write(gb_timer_pkg::ADDR_IE, 8'h01);
        take_interrupt();
        check_value("irq with rest masked", 16'(irq), 16'h0000);
        bus_read(gb_timer_pkg::ADDR_IF, d);
        check_value("IF after masked take", 16'(d), 16'h00FA);
        bus_write(gb_timer_pkg::ADDR_IF, 8'h00);
        bus_write(gb_timer_pkg::ADDR_IE, 8'h00);
    endtask

    task automatic read_back(input gb_timer_pkg::addr_t a, input gb_timer_pkg::data_t d,
                             input gb_timer_pkg::data_t expected);
        gb_timer_pkg::data_t r;
        bus_write(a, d);
        bus_read(a, r);
        check_value($sformatf("readback at %h", a), 16'(r), 16'(expected));
    endtask

    task automatic test_bus_map();
        gb_timer_pkg::data_t d;
        gb_timer_pkg::data_t r;
        bus_write(gb_timer_pkg::ADDR_TIMA, 8'h00);
        d = 8'($urandom);
        read_back(gb_timer_pkg::ADDR_TMA, d, d);
        d = 8'($urandom);
        read_back(gb_timer_pkg::ADDR_TAC, d, d);
        bus_write(gb_timer_pkg::ADDR_TAC, 8'h00);
        d = 8'($urandom);
        read_back(gb_timer_pkg::ADDR_IE, d, d);
        bus_write(gb_timer_pkg::ADDR_IE, 8'h00);
        d = 8'($urandom);
        read_back(gb_timer_pkg::ADDR_IF, d, {3'b111, d[4:0]});
        bus_write(gb_timer_pkg::ADDR_IF, 8'h00);
        for (int i = 0; i < 6; i++) begin
            bus_read(UNMAPPED[i], r);
            check_value($sformatf("unmapped read at %h", UNMAPPED[i]), 16'(r), 16'h00FF);
        end
        // Idle bus reads high even on a mapped register
        next_cycle();
        addr = gb_timer_pkg::ADDR_TMA;
        rd   = 1'b0;
        next_cycle();
        check_value("rdata with rd low", 16'(rdata), 16'h00FF);
        rd = 1'b1;
    endtask

    initial begin
        void'($urandom(32'h9041));
        rst       = 1'b1;
        addr      = '0;
        wdata     = '0;
        wr        = 1'b0;
        rd        = 1'b0;
        irq_ext   = 4'h0;
        irq_taken = 1'b0;
        repeat (2) @(posedge clk_1m);
        @(negedge clk_1m);
        rst = 1'b0;
        test_div();
        for (int s = 0; s < 4; s++) begin
            test_tima(2'(s));
        end
        test_overflow();
        test_priority();
        test_bus_map();
        next_cycle();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- sim.f
verilog/gb_timer_pkg.sv
verilog/io_bus.sv
verilog/timer.sv
verilog/interrupt_ctrl.sv
verilog/timer_subsystem.sv
tb/tb_timer_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the timer subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_timer_subsystem \
    -f sim.f \
    -o sim_tb_timer_subsystem

# The log decides the result, the pipe keeps the output visible
./obj_dir/sim_tb_timer_subsystem | tee sim.log

if grep -qx "Verification passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
